// ==== vwriter_pkg.sv ====
/* shared widths, beat and burst types, AXI response and beat state enums
   for the vector store engine */
package vwriter_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int addr_w  = 18;  // byte address
  localparam int bytes_w = 11;  // command byte count, 1..1024
  localparam int lanes   = 8;   // bytes per beat, data and AXI alike
  localparam int lane_w  = 3;   // lane offset
  localparam int bcnt_w  = 4;   // bytes in one beat, 0..8
  localparam int avail_w = 5;   // aligner residue count, 0..16

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------
  typedef logic [addr_w-1:0]    addr_t;
  typedef logic [bytes_w-1:0]   nbytes_t;
  typedef logic [7:0]           len_t;    // AXI beats minus one
  typedef logic [lanes*8-1:0]   beat_t;
  typedef logic [lanes-1:0]     strb_t;
  typedef logic [lane_w-1:0]    ofs_t;
  typedef logic [bcnt_w-1:0]    bcnt_t;
  typedef logic [avail_w-1:0]   avail_t;

  // per burst info, planner to sequencer
  typedef struct packed {
    ofs_t  ofs;         // lane of the first byte
    len_t  len;         // beats minus one
    bcnt_t first_bcnt;  // bytes in first beat
    bcnt_t last_bcnt;   // bytes in last beat, 0 for single beat bursts
  } burst_attr_t;

  // ----------------------------------------------------------
  // enums
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_exokay = 2'd1,
    resp_slverr = 2'd2,
    resp_decerr = 2'd3
  } axi_resp_e;

  // W beat sequencer
  typedef enum logic [1:0] {
    idle       = 2'd0,
    first_beat = 2'd1,
    body_beat  = 2'd2
  } beat_state_e;

endpackage

// ==== pipe_fifo.sv ====
/* two-entry valid/ready register FIFO, width set by parameter */
`timescale 1ns/10ps

module pipe_fifo #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [width-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [width-1:0] out_data
);

  logic [width-1:0] mem [2];  // entry storage
  logic [1:0]       count;    // 0..2 entries
  logic             rd_ptr;
  logic             wr_ptr;
  logic             push;
  logic             pop;

  // flags straight from the count
  assign in_ready  = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];  // head entry

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count  <= '0;
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};  // push and pop may coincide
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  // an offer refused while full stays put until it is taken
  a_hold_while_full: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

// ==== burst_planner.sv ====
/* command FIFO, burst attribute calculation, AW FIFO and attribute FIFO */
`timescale 1ns/10ps

module burst_planner
  import vwriter_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // command in
  input  logic        ctrl_valid,
  output logic        ctrl_ready,
  input  addr_t       ctrl_addr,
  input  nbytes_t     ctrl_num_bytes,
  // AW out
  output logic        aw_valid,
  input  logic        aw_ready,
  output addr_t       aw_addr,
  output len_t        aw_len,
  // attributes to sequencer
  output logic        attr_valid,
  input  logic        attr_ready,
  output burst_attr_t attr
);

  logic        cmd_valid;    // head of command FIFO
  logic        cmd_ready;
  addr_t       cmd_addr;
  nbytes_t     cmd_nbytes;
  logic        aw_in_valid;
  logic        aw_in_ready;
  logic        at_in_valid;
  logic        at_in_ready;
  bcnt_t       room;         // bytes left in the first beat
  nbytes_t     rest;         // bytes after the first beat
  ofs_t        rem;          // partial last beat
  burst_attr_t attr_new;

  pipe_fifo #(.width(addr_w + bytes_w)) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ctrl_valid),
    .in_ready  (ctrl_ready),
    .in_data   ({ctrl_addr, ctrl_num_bytes}),
    .out_valid (cmd_valid),
    .out_ready (cmd_ready),
    .out_data  ({cmd_addr, cmd_nbytes})
  );

  // ----------------------------------------------------------
  // burst attributes of the head command
  // ----------------------------------------------------------
  always_comb begin
    attr_new.ofs = cmd_addr[lane_w-1:0];
    room         = bcnt_t'(lanes) - {1'b0, attr_new.ofs};
    // first beat: smaller of count and room in the beat
    attr_new.first_bcnt = (cmd_nbytes < nbytes_t'(room)) ? bcnt_t'(cmd_nbytes) : room;
    rest = cmd_nbytes - nbytes_t'(attr_new.first_bcnt);
    rem  = rest[lane_w-1:0];
    attr_new.len       = rest[bytes_w-1:lane_w] + len_t'(rem != '0);  // whole beats plus tail
    attr_new.last_bcnt = (rest != '0 && rem == '0) ? bcnt_t'(lanes) : {1'b0, rem};
  end

  // both FIFOs take the command in the same cycle
  assign aw_in_valid = cmd_valid & at_in_ready;
  assign at_in_valid = cmd_valid & aw_in_ready;
  assign cmd_ready   = aw_in_ready & at_in_ready;

  pipe_fifo #(.width(addr_w + 8)) u_aw_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (aw_in_valid),
    .in_ready  (aw_in_ready),
    .in_data   ({cmd_addr, attr_new.len}),
    .out_valid (aw_valid),
    .out_ready (aw_ready),
    .out_data  ({aw_addr, aw_len})
  );

  pipe_fifo #(.width($bits(burst_attr_t))) u_attr_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (at_in_valid),
    .in_ready  (at_in_ready),
    .in_data   (attr_new),
    .out_valid (attr_valid),
    .out_ready (attr_ready),
    .out_data  (attr)
  );

  // zero length commands are not legal at the client port
  a_nbytes_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> cmd_nbytes != '0);

endmodule

// ==== byte_aligner.sv ====
/* store buffer and byte residue register, hands out a requested byte count
   at a requested lane offset */
`timescale 1ns/10ps

module byte_aligner
  import vwriter_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  // client data
  input  logic   data_valid,
  output logic   data_ready,
  input  beat_t  data_data,
  input  strb_t  data_pred,
  // sequencer side
  input  logic   take,
  input  ofs_t   take_ofs,
  input  bcnt_t  take_bcnt,
  output avail_t avail_bcnt,
  output beat_t  lane_data,
  output strb_t  lane_pred
);

  logic                   sb_valid;
  logic                   sb_ready;
  beat_t                  sb_data;
  strb_t                  sb_pred;
  logic                   refill;
  logic [2*lanes*8-1:0]   res_data;  // oldest byte in byte 0
  logic [2*lanes-1:0]     res_pred;
  avail_t                 res_cnt;
  avail_t                 kept;      // bytes left after this take
  bcnt_t                  drop;
  logic [2*lanes*8-1:0]   keep_mask;
  logic [2*lanes*8-1:0]   nxt_data;
  logic [2*lanes-1:0]     nxt_pred;
  strb_t                  bmask;     // lanes 0..take_bcnt-1
  beat_t                  dmask;

  // store buffer, predicates ride with the data
  pipe_fifo #(.width(lanes*9)) u_store_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (data_valid),
    .in_ready  (data_ready),
    .in_data   ({data_pred, data_data}),
    .out_valid (sb_valid),
    .out_ready (sb_ready),
    .out_data  ({sb_pred, sb_data})
  );

  // ----------------------------------------------------------
  // residue update
  // ----------------------------------------------------------
  assign sb_ready   = (res_cnt <= avail_t'(lanes));  // room for a whole word
  assign refill     = sb_valid & sb_ready;
  assign avail_bcnt = res_cnt;

  always_comb begin
    drop = take ? take_bcnt : '0;
    kept = res_cnt - {1'b0, drop};
    // stale bytes above kept are masked off before the new word lands
    keep_mask = ~({(2*lanes*8){1'b1}} << (8 * kept));
    nxt_data  = (res_data >> (8 * drop)) & keep_mask;
    nxt_pred  = (res_pred >> drop) & ~({(2*lanes){1'b1}} << kept);
    if (refill) begin
      nxt_data = nxt_data | ({{(lanes*8){1'b0}}, sb_data} << (8 * kept));
      nxt_pred = nxt_pred | ({{lanes{1'b0}}, sb_pred} << kept);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      res_cnt <= '0;
    else
      res_cnt <= kept + (refill ? avail_t'(lanes) : '0);
  end

  always_ff @(posedge clk) begin
    res_data <= nxt_data;
    res_pred <= nxt_pred;
  end

  // ----------------------------------------------------------
  // lane placement
  // ----------------------------------------------------------
  always_comb begin
    bmask = ~(strb_t'('1) << take_bcnt);
    for (int i = 0; i < lanes; i++) begin
      dmask[i*8 +: 8] = {8{bmask[i]}};  // byte mask to bit mask
    end
  end

  // oldest bytes moved up to take_ofs, other lanes zero
  assign lane_data = (res_data[lanes*8-1:0] & dmask) << (8 * take_ofs);
  assign lane_pred = (res_pred[lanes-1:0] & bmask) << take_ofs;

  // sequencer only takes what the residue already holds
  a_take_avail: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> avail_t'(take_bcnt) <= avail_bcnt);

endmodule

// ==== wbeat_sequencer.sv ====
/* W beat FSM, pops burst attributes and issues aligned beats with
   strobes and last flag */
`timescale 1ns/10ps

module wbeat_sequencer
  import vwriter_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // burst attributes
  input  logic        attr_valid,
  output logic        attr_ready,
  input  burst_attr_t attr,
  // aligner
  input  avail_t      avail_bcnt,
  input  beat_t       lane_data,
  input  strb_t       lane_pred,
  output logic        take,
  output ofs_t        take_ofs,
  output bcnt_t       take_bcnt,
  // W beats to FIFO
  output logic        beat_valid,
  input  logic        beat_ready,
  output beat_t       beat_data,
  output strb_t       beat_strb,
  output logic        beat_last
);

  beat_state_e state;
  beat_state_e state_nxt;
  burst_attr_t cur;          // attributes of the burst in flight
  len_t        beats_left;   // beats after the current one
  logic        last_beat;
  logic        fire;         // beat enters W FIFO
  logic        pop;          // attribute popped
  strb_t       range_mask;

  assign last_beat = (beats_left == '0);

  // ----------------------------------------------------------
  // beat shape
  // ----------------------------------------------------------
  always_comb begin
    take_ofs  = '0;
    take_bcnt = bcnt_t'(lanes);  // middle beats are full
    case (state)
      first_beat: begin
        take_ofs  = cur.ofs;
        take_bcnt = cur.first_bcnt;
      end
      body_beat: begin
        if (last_beat) take_bcnt = cur.last_bcnt;
      end
      default: take_bcnt = '0;
    endcase
  end

  // beat goes out once the aligner holds enough bytes
  assign beat_valid = (state != idle) && (avail_bcnt >= avail_t'(take_bcnt));
  assign fire       = beat_valid & beat_ready;
  assign take       = fire;

  assign range_mask = strb_t'(~(strb_t'('1) << take_bcnt) << take_ofs);
  assign beat_strb  = range_mask & lane_pred;  // predicates gate the strobe
  assign beat_data  = lane_data;
  assign beat_last  = (state != idle) & last_beat;

  // next attribute while idle or right on the last beat
  assign attr_ready = (state == idle) | (fire & last_beat);
  assign pop        = attr_valid & attr_ready;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin
    state_nxt = state;
    if (pop)
      state_nxt = first_beat;  // back to back bursts skip idle
    else if (fire)
      state_nxt = last_beat ? idle : body_beat;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      beats_left <= '0;
    end else begin
      state <= state_nxt;
      if (pop)
        beats_left <= attr.len;
      else if (fire && !last_beat)
        beats_left <= beats_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) cur <= attr;
  end

endmodule

// ==== axi_vwriter.sv ====
/* vector store engine top, burst planner and byte aligner side by side,
   W beat sequencer joins them, W and B FIFOs at the AXI side */
`timescale 1ns/10ps

module axi_vwriter
  import vwriter_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // command
  input  logic      ctrl_valid,
  output logic      ctrl_ready,
  input  addr_t     ctrl_addr,
  input  nbytes_t   ctrl_num_bytes,
  // store data
  input  logic      data_valid,
  output logic      data_ready,
  input  beat_t     data_data,
  input  strb_t     data_pred,
  // AW
  output logic      aw_valid,
  input  logic      aw_ready,
  output addr_t     aw_addr,
  output len_t      aw_len,
  // W
  output logic      w_valid,
  input  logic      w_ready,
  output beat_t     w_data,
  output strb_t     w_strb,
  output logic      w_last,
  // B
  input  logic      b_valid,
  output logic      b_ready,
  input  axi_resp_e b_resp,
  // response to client
  output logic      resp_valid,
  input  logic      resp_ready,
  output axi_resp_e resp_resp
);

  logic        attr_valid;
  logic        attr_ready;
  burst_attr_t attr;
  avail_t      avail_bcnt;
  beat_t       lane_data;
  strb_t       lane_pred;
  logic        take;
  ofs_t        take_ofs;
  bcnt_t       take_bcnt;
  logic        beat_valid;
  logic        beat_ready;
  beat_t       beat_data;
  strb_t       beat_strb;
  logic        beat_last;
  logic [1:0]  b_q;  // response out of B FIFO

  burst_planner u_planner (
    .clk, .rst_n,
    .ctrl_valid, .ctrl_ready, .ctrl_addr, .ctrl_num_bytes,
    .aw_valid, .aw_ready, .aw_addr, .aw_len,
    .attr_valid, .attr_ready, .attr
  );

  byte_aligner u_aligner (
    .clk, .rst_n,
    .data_valid, .data_ready, .data_data, .data_pred,
    .take, .take_ofs, .take_bcnt,
    .avail_bcnt, .lane_data, .lane_pred
  );

  wbeat_sequencer u_sequencer (
    .clk, .rst_n,
    .attr_valid, .attr_ready, .attr,
    .avail_bcnt, .lane_data, .lane_pred,
    .take, .take_ofs, .take_bcnt,
    .beat_valid, .beat_ready, .beat_data, .beat_strb, .beat_last
  );

  // ----------------------------------------------------------
  // AXI side FIFOs
  // ----------------------------------------------------------
  pipe_fifo #(.width(lanes*9 + 1)) u_w_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (beat_valid),
    .in_ready  (beat_ready),
    .in_data   ({beat_last, beat_strb, beat_data}),
    .out_valid (w_valid),
    .out_ready (w_ready),
    .out_data  ({w_last, w_strb, w_data})
  );

  // single AW ID, responses come back in order
  pipe_fifo #(.width(2)) u_b_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .in_data   (b_resp),
    .out_valid (resp_valid),
    .out_ready (resp_ready),
    .out_data  (b_q)
  );

  assign resp_resp = axi_resp_e'(b_q);

endmodule

// ==== tb_axi_vwriter_checks.svh ====
/* compare tasks for AW, W, response and flag results, plus the
   cycle guard and drain wait with timeouts */
`ifndef tb_axi_vwriter_checks_svh
`define tb_axi_vwriter_checks_svh

// ------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------
task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
  stop_with_failure($sformatf("ERR t=%0t %s expected %h got %h",
                              $time, sig, exp_val, act_val));
endtask

task automatic check_flag(input string sig, input logic exp_val, input logic act_val);
  if (act_val !== exp_val) report_mismatch(sig, exp_val, act_val);
endtask

task automatic check_aw(input addr_t addr, input len_t len);
  addr_t exp_addr;
  len_t  exp_len;
  if (exp_aw_addr.size() == 0)
    stop_with_failure("AW burst seen with no command left to match it");
  exp_addr = exp_aw_addr.pop_front();
  exp_len  = exp_aw_len.pop_front();
  if (addr !== exp_addr) report_mismatch("aw_addr", exp_addr, addr);
  if (len !== exp_len)   report_mismatch("aw_len", exp_len, len);
endtask

task automatic check_w(input beat_t data, input strb_t strb, input logic last);
  if (exp_w_data.size() == 0)
    stop_with_failure("W beat seen with no expected beat left");
  if (data !== exp_w_data[0]) report_mismatch("w_data", exp_w_data[0], data);
  if (strb !== exp_w_strb[0]) report_mismatch("w_strb", exp_w_strb[0], strb);
  if (last !== exp_w_last[0]) report_mismatch("w_last", exp_w_last[0], last);
  void'(exp_w_data.pop_front());
  void'(exp_w_strb.pop_front());
  void'(exp_w_last.pop_front());
endtask

task automatic check_resp(input axi_resp_e resp);
  axi_resp_e exp_r;
  if (exp_resp.size() == 0)
    stop_with_failure("response seen before any B response was sent");
  exp_r = exp_resp.pop_front();
  if (resp !== exp_r) report_mismatch("resp_resp", exp_r, resp);
  resp_seen++;
endtask

// ------------------------------------------------------------
// timeouts
// ------------------------------------------------------------
task automatic count_wait_cycle(inout int guard, input string what);
  guard++;
  if (guard > hs_limit)
    stop_with_failure($sformatf("timeout, no handshake on %s", what));
endtask

// all bursts written and answered
task automatic wait_for_drain();
  int guard;
  guard = 0;
  while (exp_w_data.size() != 0 || exp_aw_addr.size() != 0 || resp_seen != n_cmds) begin
    @(posedge clk);
    guard++;
    if (guard > drain_limit)
      stop_with_failure("timeout, AW, W or response traffic stopped before the end");
  end
endtask

`endif

// ==== tb_axi_vwriter.sv ====
/* testbench for the vector store engine, stimulus, AXI slave model,
   reference burst function and compare process */
`timescale 1ns/10ps

module tb_axi_vwriter
  import vwriter_pkg::*;
();

  localparam int n_cmds      = 40;
  localparam int hs_limit    = 2000;  // cycles per handshake
  localparam int drain_limit = 5000;

  logic      clk;
  logic      rst_n;
  logic      ctrl_valid, ctrl_ready;
  addr_t     ctrl_addr;
  nbytes_t   ctrl_num_bytes;
  logic      data_valid, data_ready;
  beat_t     data_data;
  strb_t     data_pred;
  logic      aw_valid, aw_ready;
  addr_t     aw_addr;
  len_t      aw_len;
  logic      w_valid, w_ready, w_last;
  beat_t     w_data;
  strb_t     w_strb;
  logic      b_valid, b_ready;
  axi_resp_e b_resp;
  logic      resp_valid, resp_ready;
  axi_resp_e resp_resp;

  integer      seed;
  logic [31:0] slave_rnd;
  int          b_owed;      // w_last beats not yet answered
  bit          b_done;
  int          resp_seen;
  // stimulus and expected traffic
  addr_t       cmd_addr_q[$];
  nbytes_t     cmd_nb_q[$];
  beat_t       word_data[$];
  strb_t       word_pred[$];
  logic [7:0]  byte_q[$];    // byte stream, oldest first
  logic        pred_q[$];
  addr_t       exp_aw_addr[$];
  len_t        exp_aw_len[$];
  beat_t       exp_w_data[$];
  strb_t       exp_w_strb[$];
  logic        exp_w_last[$];
  axi_resp_e   exp_resp[$];

  axi_vwriter dut (.*);

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  `include "tb_axi_vwriter_checks.svh"

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  // fill lanes from the address offset upward, one beat per full lane set
  function automatic void expect_burst(input addr_t addr, input nbytes_t nb);
    beat_t data;
    strb_t strb;
    int    lane;
    int    beats;
    data  = '0;
    strb  = '0;
    lane  = addr[lane_w-1:0];
    beats = 0;
    for (int i = 0; i < nb; i++) begin
      data[lane*8 +: 8] = byte_q.pop_front();
      strb[lane]        = pred_q.pop_front();  // predicate gates the strobe
      lane++;
      if (lane == lanes || i == nb - 1) begin
        exp_w_data.push_back(data);
        exp_w_strb.push_back(strb);
        exp_w_last.push_back(i == nb - 1);
        data = '0;
        strb = '0;
        lane = 0;
        beats++;
      end
    end
    exp_aw_addr.push_back(addr);
    exp_aw_len.push_back(len_t'(beats - 1));
  endfunction

  function automatic void build_stimulus();
    logic [31:0] r;
    addr_t       a;
    nbytes_t     nb;
    int          total;
    total = 0;
    for (int i = 0; i < n_cmds; i++) begin
      r  = $random(seed);
      a  = addr_t'(r);
      nb = nbytes_t'(r[29:24]) + 1'b1;  // 1..64
      if (i < lanes) begin
        a[lane_w-1:0] = i;  // every offset once
        if (i == 0) nb = 1;
        if (i == lanes - 1) nb = 64;
      end
      cmd_addr_q.push_back(a);
      cmd_nb_q.push_back(nb);
      total += nb;
    end
    for (int w = 0; w < (total + lanes - 1) / lanes; w++) begin
      word_data.push_back({$random(seed), $random(seed)});
      word_pred.push_back(strb_t'($random(seed)));
      for (int k = 0; k < lanes; k++) begin
        byte_q.push_back(word_data[w][k*8 +: 8]);  // lane 0 goes first
        pred_q.push_back(word_pred[w][k]);
      end
    end
    for (int i = 0; i < n_cmds; i++) expect_burst(cmd_addr_q[i], cmd_nb_q[i]);
  endfunction

  // ------------------------------------------------------------
  // client drivers
  // ------------------------------------------------------------
  task automatic send_commands();
    int   guard;
    logic hs;
    for (int i = 0; i < n_cmds; i++) begin
      if (($random(seed) & 3) == 0) begin  // idle cycle
        @(posedge clk);
        #1;
      end
      ctrl_valid     = 1'b1;
      ctrl_addr      = cmd_addr_q[i];
      ctrl_num_bytes = cmd_nb_q[i];
      guard = 0;
      hs    = 1'b0;
      while (!hs) begin
        @(negedge clk);
        hs = ctrl_ready;  // transfer on the coming edge
        @(posedge clk);
        #1;
        count_wait_cycle(guard, "ctrl_ready");
      end
      ctrl_valid = 1'b0;
    end
  endtask

  task automatic send_data_words();
    int   guard;
    logic hs;
    for (int i = 0; i < word_data.size(); i++) begin
      if (($random(seed) & 3) == 0) begin
        @(posedge clk);
        #1;
      end
      data_valid = 1'b1;
      data_data  = word_data[i];
      data_pred  = word_pred[i];
      guard = 0;
      hs    = 1'b0;
      while (!hs) begin
        @(negedge clk);
        hs = data_ready;
        @(posedge clk);
        #1;
        count_wait_cycle(guard, "data_ready");
      end
      data_valid = 1'b0;
    end
  endtask

  // ------------------------------------------------------------
  // slave model and compare process
  // ------------------------------------------------------------
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      aw_ready   = 1'b0;
      w_ready    = 1'b0;
      resp_ready = 1'b0;
      b_valid    = 1'b0;
    end else begin
      slave_rnd  = $random(seed);
      aw_ready   = |slave_rnd[1:0];  // ready 3 cycles in 4
      w_ready    = |slave_rnd[3:2];
      resp_ready = |slave_rnd[5:4];
      if (b_done) begin
        b_valid = 1'b0;
        b_done  = 1'b0;
      end
      if (!b_valid && b_owed > 0 && slave_rnd[6]) begin
        b_valid = 1'b1;
        b_resp  = axi_resp_e'(slave_rnd[9:8]);  // okay, exokay, slverr, decerr
        b_owed--;
      end
    end
  end

  // handshakes sampled mid cycle, transfer follows on the next edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (aw_valid && aw_ready) check_aw(aw_addr, aw_len);
      if (w_valid && w_ready) begin
        check_w(w_data, w_strb, w_last);
        if (w_last) b_owed++;
      end
      if (b_valid && b_ready) begin
        exp_resp.push_back(b_resp);
        b_done = 1'b1;
      end
      if (resp_valid && resp_ready) check_resp(resp_resp);
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    ctrl_valid     = 1'b0;
    ctrl_addr      = '0;
    ctrl_num_bytes = '0;
    data_valid     = 1'b0;
    data_data      = '0;
    data_pred      = '0;
    aw_ready       = 1'b0;
    w_ready        = 1'b0;
    b_valid        = 1'b0;
    b_resp         = resp_okay;
    resp_ready     = 1'b0;
    b_owed         = 0;
    b_done         = 1'b0;
    resp_seen      = 0;
    seed           = 32'h1f5ce559;
    build_stimulus();
    @(posedge clk);
    repeat (7) begin
      @(negedge clk);
      check_flag("aw_valid", 1'b0, aw_valid);
      check_flag("w_valid", 1'b0, w_valid);
      check_flag("resp_valid", 1'b0, resp_valid);
      @(posedge clk);
    end
    #1;
    rst_n = 1'b1;  // out of reset after 8 edges
    @(negedge clk);
    check_flag("ctrl_ready", 1'b1, ctrl_ready);
    check_flag("data_ready", 1'b1, data_ready);
    check_flag("b_ready", 1'b1, b_ready);  // B FIFO empty
    check_flag("aw_valid", 1'b0, aw_valid);
    check_flag("w_valid", 1'b0, w_valid);
    check_flag("resp_valid", 1'b0, resp_valid);
    @(posedge clk);
    #1;
    fork
      send_commands();
      send_data_words();
    join
    wait_for_drain();
    @(negedge clk);
    // a valid still up here is a beat beyond the expected bursts
    if (!aw_valid && !w_valid && !resp_valid && exp_resp.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_with_failure("extra AW, W or response traffic after the last burst");
    end
  end

endmodule

// ==== axi_vwriter.f ====
+incdir+.
vwriter_pkg.sv
pipe_fifo.sv
burst_planner.sv
byte_aligner.sv
wbeat_sequencer.sv
axi_vwriter.sv
tb_axi_vwriter.sv
